/* verilog/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int DEFAULT_DATA_W = 16;
    localparam int OPCODE_W       = 8;
    localparam int SEL_W          = 4;
    localparam int FLAG_W         = 4;

    // alu operations
    localparam logic [OPCODE_W-1:0] OP_NOP    = 8'h00;
    localparam logic [OPCODE_W-1:0] OP_ADD    = 8'h01;
    localparam logic [OPCODE_W-1:0] OP_SUB    = 8'h02;
    localparam logic [OPCODE_W-1:0] OP_AND    = 8'h03;
    localparam logic [OPCODE_W-1:0] OP_OR     = 8'h04;
    localparam logic [OPCODE_W-1:0] OP_NOT    = 8'h05;
    localparam logic [OPCODE_W-1:0] OP_XOR    = 8'h06;
    localparam logic [OPCODE_W-1:0] OP_RAND   = 8'h07;
    localparam logic [OPCODE_W-1:0] OP_ROR    = 8'h08;
    localparam logic [OPCODE_W-1:0] OP_RXOR   = 8'h09;
    localparam logic [OPCODE_W-1:0] OP_LSL    = 8'h0A;
    localparam logic [OPCODE_W-1:0] OP_LSR    = 8'h0B;
    localparam logic [OPCODE_W-1:0] OP_ASL    = 8'h0C;
    localparam logic [OPCODE_W-1:0] OP_ASR    = 8'h0D;
    localparam logic [OPCODE_W-1:0] OP_CSL    = 8'h0E;
    localparam logic [OPCODE_W-1:0] OP_CSR    = 8'h0F;
    localparam logic [OPCODE_W-1:0] OP_INC    = 8'h10;
    localparam logic [OPCODE_W-1:0] OP_DEC    = 8'h11;

    // stack and move operations
    localparam logic [OPCODE_W-1:0] OP_PUSH   = 8'hFB;
    localparam logic [OPCODE_W-1:0] OP_POP    = 8'hFC;
    localparam logic [OPCODE_W-1:0] OP_MOV_RA = 8'hFD;
    localparam logic [OPCODE_W-1:0] OP_MOV_AR = 8'hFE;
    localparam logic [OPCODE_W-1:0] OP_MOV_RR = 8'hFF;

    localparam logic [SEL_W-1:0] SEL_NONE   = 4'd0;
    localparam logic [SEL_W-1:0] SEL_A      = 4'd1;
    localparam logic [SEL_W-1:0] SEL_B      = 4'd2;
    localparam logic [SEL_W-1:0] SEL_C      = 4'd3;
    localparam logic [SEL_W-1:0] SEL_D      = 4'd4;
    localparam logic [SEL_W-1:0] SEL_E      = 4'd5;
    localparam logic [SEL_W-1:0] SEL_F      = 4'd6;
    // read side is R, write side is SS
    localparam logic [SEL_W-1:0] SEL_R_SS   = 4'd7;
    // read side is the immediate, write side is SP
    localparam logic [SEL_W-1:0] SEL_IMM_SP = 4'd8;

    localparam logic [1:0] FLAG_OVF   = 2'd0;
    localparam logic [1:0] FLAG_ZERO  = 2'd1;
    localparam logic [1:0] FLAG_CARRY = 2'd2;
    localparam logic [1:0] FLAG_STACK = 2'd3;

endpackage

`default_nettype wire

/* verilog/alu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_core #(
    parameter int DATA_W = 16
) (
    input  wire  [alu_pkg::OPCODE_W-1:0] opcode_i,
    input  wire  [DATA_W-1:0]            operand_a_i,
    input  wire  [DATA_W-1:0]            operand_b_i,
    output logic [DATA_W-1:0]            result_o,
    output logic                         carry_o,
    output logic                         ovf_o
);

    localparam int MSB = DATA_W - 1;

    logic [DATA_W:0] add_ext;
    logic [DATA_W:0] sub_ext;

    // one extra bit holds the carry out or the borrow
    assign add_ext = {1'b0, operand_a_i} + {1'b0, operand_b_i};
    assign sub_ext = {1'b0, operand_a_i} - {1'b0, operand_b_i};

    always_comb begin
        result_o = '0;
        carry_o  = 1'b0;
        ovf_o    = 1'b0;
        case (opcode_i)
            alu_pkg::OP_ADD: begin
                result_o = add_ext[MSB:0];
                carry_o  = add_ext[DATA_W];
                ovf_o    = (operand_a_i[MSB] == operand_b_i[MSB]) &&
                           (add_ext[MSB] != operand_a_i[MSB]);
            end
            alu_pkg::OP_SUB: begin
                result_o = sub_ext[MSB:0];
                carry_o  = sub_ext[DATA_W];
                ovf_o    = (operand_a_i[MSB] != operand_b_i[MSB]) &&
                           (sub_ext[MSB] != operand_a_i[MSB]);
            end
            alu_pkg::OP_AND: result_o = operand_a_i & operand_b_i;
            alu_pkg::OP_OR:  result_o = operand_a_i | operand_b_i;
            alu_pkg::OP_NOT: result_o = ~operand_a_i;
            alu_pkg::OP_XOR: result_o = operand_a_i ^ operand_b_i;
            // reductions land in bit 0
            alu_pkg::OP_RAND: result_o = {{(DATA_W-1){1'b0}}, &operand_a_i};
            alu_pkg::OP_ROR:  result_o = {{(DATA_W-1){1'b0}}, |operand_a_i};
            alu_pkg::OP_RXOR: result_o = {{(DATA_W-1){1'b0}}, ^operand_a_i};
            alu_pkg::OP_LSL, alu_pkg::OP_ASL: begin
                result_o = {operand_a_i[MSB-1:0], 1'b0};
                carry_o  = operand_a_i[MSB];
            end
            alu_pkg::OP_LSR: result_o = {1'b0, operand_a_i[MSB:1]};
            alu_pkg::OP_ASR: result_o = {operand_a_i[MSB], operand_a_i[MSB:1]};
            alu_pkg::OP_CSL: result_o = {operand_a_i[MSB-1:0], operand_a_i[MSB]};
            alu_pkg::OP_CSR: result_o = {operand_a_i[0], operand_a_i[MSB:1]};
            alu_pkg::OP_INC: result_o = operand_a_i + DATA_W'(1);
            alu_pkg::OP_DEC: result_o = operand_a_i - DATA_W'(1);
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/stack_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module stack_unit #(
    parameter int DATA_W = 16
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               push_i,
    input  wire               pop_i,
    input  wire               ss_we_i,
    input  wire               sp_we_i,
    input  wire  [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] addr_o,
    output logic              addr_valid_o,
    output logic              stack_flag_o
);

    logic [DATA_W-1:0] ss_q;
    logic [DATA_W-1:0] sp_q;
    logic              sp_max;
    logic              sp_zero;

    assign sp_max  = &sp_q;
    assign sp_zero = ~|sp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ss_q         <= '0;
            sp_q         <= '0;
            addr_valid_o <= 1'b0;
            stack_flag_o <= 1'b0;
        end else begin
            if (ss_we_i) begin
                ss_q <= wdata_i;
            end
            // explicit write beats the pop decrement
            if (sp_we_i) begin
                sp_q <= wdata_i;
            end else if (push_i && !sp_max) begin
                sp_q <= sp_q + DATA_W'(1);
            end else if (pop_i && !sp_zero) begin
                sp_q <= sp_q - DATA_W'(1);
            end
            addr_valid_o <= push_i || pop_i;
            if (push_i) begin
                stack_flag_o <= sp_max;
            end else if (pop_i) begin
                stack_flag_o <= sp_zero;
            end
        end
    end

    // pop reads the slot below the pointer
    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_o <= ss_q + sp_q;
        end else if (pop_i) begin
            addr_o <= ss_q + sp_q - DATA_W'(1);
        end
    end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module register_bank #(
    parameter int DATA_W = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          op_valid_i,
    input  wire  [alu_pkg::OPCODE_W-1:0] opcode_i,
    input  wire  [alu_pkg::SEL_W-1:0]    sel_a_i,
    input  wire  [alu_pkg::SEL_W-1:0]    sel_b_i,
    input  wire  [DATA_W-1:0]            data_i_i,
    input  wire  [DATA_W-1:0]            alu_result_i,
    input  wire                          alu_carry_i,
    input  wire                          alu_ovf_i,
    input  wire                          stack_flag_i,
    output logic [alu_pkg::OPCODE_W-1:0] alu_opcode_o,
    output logic [DATA_W-1:0]            operand_a_o,
    output logic [DATA_W-1:0]            operand_b_o,
    output logic                         push_o,
    output logic                         pop_o,
    output logic                         ss_we_o,
    output logic                         sp_we_o,
    output logic [DATA_W-1:0]            stack_wdata_o,
    output logic [DATA_W-1:0]            data_o,
    output logic                         data_valid_o,
    output logic [alu_pkg::FLAG_W-1:0]   flags_o
);

    logic [DATA_W-1:0]         gpr_q [1:6];
    logic [DATA_W-1:0]         r_q;
    logic                      ovf_q;
    logic                      zero_q;
    logic                      carry_q;
    logic [DATA_W-1:0]         rd_src [2**alu_pkg::SEL_W];
    logic                      is_alu;
    logic                      is_mov_ra;
    logic                      is_mov_ar;
    logic                      is_mov_rr;
    logic                      send;
    logic                      wr_en;
    logic                      wr_gpr;
    logic [alu_pkg::SEL_W-1:0] wr_sel;
    logic [DATA_W-1:0]         wr_data;

    // read mux shared by both operands and the outgoing data
    always_comb begin
        for (int i = 0; i < 2**alu_pkg::SEL_W; i++) begin
            rd_src[i] = '0;
        end
        for (int i = 1; i <= 6; i++) begin
            rd_src[i] = gpr_q[i];
        end
        rd_src[alu_pkg::SEL_NONE]   = '0;
        rd_src[alu_pkg::SEL_R_SS]   = r_q;
        rd_src[alu_pkg::SEL_IMM_SP] = data_i_i;
    end

    assign operand_a_o  = rd_src[sel_a_i];
    assign operand_b_o  = rd_src[sel_b_i];
    assign alu_opcode_o = opcode_i;

    assign is_alu    = op_valid_i && (opcode_i >= alu_pkg::OP_ADD) &&
                       (opcode_i <= alu_pkg::OP_DEC);
    assign push_o    = op_valid_i && (opcode_i == alu_pkg::OP_PUSH);
    assign pop_o     = op_valid_i && (opcode_i == alu_pkg::OP_POP);
    assign is_mov_ra = op_valid_i && (opcode_i == alu_pkg::OP_MOV_RA);
    assign is_mov_ar = op_valid_i && (opcode_i == alu_pkg::OP_MOV_AR);
    assign is_mov_rr = op_valid_i && (opcode_i == alu_pkg::OP_MOV_RR);
    assign send      = push_o || is_mov_ra;

    // pop targets sel_a, the moves target sel_b
    always_comb begin
        wr_en   = 1'b0;
        wr_sel  = sel_b_i;
        wr_data = data_i_i;
        if (pop_o) begin
            wr_en  = 1'b1;
            wr_sel = sel_a_i;
        end else if (is_mov_ar) begin
            wr_en = 1'b1;
        end else if (is_mov_rr) begin
            wr_en   = 1'b1;
            wr_data = operand_a_o;
        end
    end

    assign wr_gpr        = wr_en && (wr_sel >= alu_pkg::SEL_A) && (wr_sel <= alu_pkg::SEL_F);
    assign ss_we_o       = wr_en && (wr_sel == alu_pkg::SEL_R_SS);
    assign sp_we_o       = wr_en && (wr_sel == alu_pkg::SEL_IMM_SP);
    assign stack_wdata_o = wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= 6; i++) begin
                gpr_q[i] <= '0;
            end
            r_q          <= '0;
            ovf_q        <= 1'b0;
            zero_q       <= 1'b0;
            carry_q      <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            if (wr_gpr) begin
                gpr_q[wr_sel] <= wr_data;
            end
            if (is_alu) begin
                r_q     <= alu_result_i;
                ovf_q   <= alu_ovf_i;
                zero_q  <= (alu_result_i == '0);
                carry_q <= alu_carry_i;
            end
            data_valid_o <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            data_o <= operand_a_o;
        end
    end

    always_comb begin
        flags_o                      = '0;
        flags_o[alu_pkg::FLAG_OVF]   = ovf_q;
        flags_o[alu_pkg::FLAG_ZERO]  = zero_q;
        flags_o[alu_pkg::FLAG_CARRY] = carry_q;
        flags_o[alu_pkg::FLAG_STACK] = stack_flag_i;
    end

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_top #(
    parameter int DATA_W = alu_pkg::DEFAULT_DATA_W
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          op_valid_i,
    input  wire  [alu_pkg::OPCODE_W-1:0] opcode_i,
    input  wire  [alu_pkg::SEL_W-1:0]    sel_a_i,
    input  wire  [alu_pkg::SEL_W-1:0]    sel_b_i,
    input  wire  [DATA_W-1:0]            data_i_i,
    output logic [DATA_W-1:0]            data_o,
    output logic                         data_valid_o,
    output logic [DATA_W-1:0]            addr_o,
    output logic                         addr_valid_o,
    output logic [alu_pkg::FLAG_W-1:0]   flags_o
);

    logic [alu_pkg::OPCODE_W-1:0] alu_opcode;
    logic [DATA_W-1:0]            operand_a;
    logic [DATA_W-1:0]            operand_b;
    logic [DATA_W-1:0]            alu_result;
    logic                         alu_carry;
    logic                         alu_ovf;
    logic                         push;
    logic                         pop;
    logic                         ss_we;
    logic                         sp_we;
    logic [DATA_W-1:0]            stack_wdata;
    logic                         stack_flag;

    alu_core #(
        .DATA_W (DATA_W)
    ) u_core (
        .opcode_i    (alu_opcode),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .result_o    (alu_result),
        .carry_o     (alu_carry),
        .ovf_o       (alu_ovf)
    );

    stack_unit #(
        .DATA_W (DATA_W)
    ) u_stack (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .pop_i        (pop),
        .ss_we_i      (ss_we),
        .sp_we_i      (sp_we),
        .wdata_i      (stack_wdata),
        .addr_o       (addr_o),
        .addr_valid_o (addr_valid_o),
        .stack_flag_o (stack_flag)
    );

    register_bank #(
        .DATA_W (DATA_W)
    ) u_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_valid_i    (op_valid_i),
        .opcode_i      (opcode_i),
        .sel_a_i       (sel_a_i),
        .sel_b_i       (sel_b_i),
        .data_i_i      (data_i_i),
        .alu_result_i  (alu_result),
        .alu_carry_i   (alu_carry),
        .alu_ovf_i     (alu_ovf),
        .stack_flag_i  (stack_flag),
        .alu_opcode_o  (alu_opcode),
        .operand_a_o   (operand_a),
        .operand_b_o   (operand_b),
        .push_o        (push),
        .pop_o         (pop),
        .ss_we_o       (ss_we),
        .sp_we_o       (sp_we),
        .stack_wdata_o (stack_wdata),
        .data_o        (data_o),
        .data_valid_o  (data_valid_o),
        .flags_o       (flags_o)
    );

endmodule

`default_nettype wire

/* verification/alu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_checker (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         op_valid_i,
    input wire [alu_pkg::OPCODE_W-1:0] opcode_i,
    input wire                         data_valid_i,
    input wire                         addr_valid_i,
    input wire [alu_pkg::FLAG_W-1:0]   flags_i
);

    int   fail_count = 0;
    logic send_cmd;
    logic stack_cmd;

    assign send_cmd  = op_valid_i &&
                       (opcode_i == alu_pkg::OP_PUSH || opcode_i == alu_pkg::OP_MOV_RA);
    assign stack_cmd = op_valid_i &&
                       (opcode_i == alu_pkg::OP_PUSH || opcode_i == alu_pkg::OP_POP);

    data_valid_after_send: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid_i == $past(send_cmd))
        else begin
            $error("data_valid_o does not follow a push or mov_ra strobe");
            fail_count++;
        end

    addr_valid_after_stack: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid_i == $past(stack_cmd))
        else begin
            $error("addr_valid_o does not follow a push or pop strobe");
            fail_count++;
        end

    flags_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(flags_i))
        else begin
            $error("flags_o is unknown");
            fail_count++;
        end

endmodule

bind alu_top alu_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid_i   (op_valid_i),
    .opcode_i     (opcode_i),
    .data_valid_i (data_valid_o),
    .addr_valid_i (addr_valid_o),
    .flags_i      (flags_o)
);

`default_nettype wire

/* verification/alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_tb;

    localparam int W          = alu_pkg::DEFAULT_DATA_W;
    localparam int CLK_PERIOD = 4;
    localparam int ALU_LEN    = 40;
    localparam int STACK_LEN  = 12;
    localparam int MIX_LEN    = 300;
    // upper bound on the commands of all tests and their register loads
    localparam int N_CMDS     = 80 + 3 * ALU_LEN + 3 * STACK_LEN + MIX_LEN;
    localparam int TIMEOUT_NS = (N_CMDS + 50) * CLK_PERIOD;
    localparam longint SMAX   = (longint'(1) << (W - 1)) - 1;
    localparam longint SMIN   = -SMAX - 1;

    logic                         clk;
    logic                         rst_n;
    logic                         op_valid_i;
    logic [alu_pkg::OPCODE_W-1:0] opcode_i;
    logic [alu_pkg::SEL_W-1:0]    sel_a_i;
    logic [alu_pkg::SEL_W-1:0]    sel_b_i;
    logic [W-1:0]                 data_i_i;
    logic [W-1:0]                 data_o;
    logic                         data_valid_o;
    logic [W-1:0]                 addr_o;
    logic                         addr_valid_o;
    logic [alu_pkg::FLAG_W-1:0]   flags_o;

    // reference model state
    logic [W-1:0] m_gpr [1:6];
    logic [W-1:0] m_r;
    logic [W-1:0] m_ss;
    logic [W-1:0] m_sp;
    logic         m_ovf;
    logic         m_zero;
    logic         m_carry;
    logic         m_stk;
    logic         exp_dv;
    logic         exp_av;
    logic [W-1:0] exp_data;
    logic [W-1:0] exp_addr;

    integer seed = 89;
    int     checks = 0;
    int     test_errors = 0;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     assert_failures = 0;

    alu_top #(
        .DATA_W (W)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid_i   (op_valid_i),
        .opcode_i     (opcode_i),
        .sel_a_i      (sel_a_i),
        .sel_b_i      (sel_b_i),
        .data_i_i     (data_i_i),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .addr_o       (addr_o),
        .addr_valid_o (addr_valid_o),
        .flags_o      (flags_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [W-1:0] rand_word();
        return W'($random(seed));
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [W-1:0] model_read(input logic [3:0] sel, input logic [W-1:0] imm);
        if (sel >= 4'd1 && sel <= 4'd6) begin
            return m_gpr[sel];
        end else if (sel == 4'd7) begin
            return m_r;
        end else if (sel == 4'd8) begin
            return imm;
        end
        return '0;
    endfunction

    // code 7 as a target is SS and code 8 is SP
    function automatic void model_write(input logic [3:0] sel, input logic [W-1:0] value);
        if (sel >= 4'd1 && sel <= 4'd6) begin
            m_gpr[sel] = value;
        end else if (sel == 4'd7) begin
            m_ss = value;
        end else if (sel == 4'd8) begin
            m_sp = value;
        end
    endfunction

    function automatic void model_alu(input logic [7:0] op, input logic [W-1:0] a,
                                      input logic [W-1:0] b);
        longint       sa;
        longint       sb;
        longint       sr;
        logic [W-1:0] res;
        sa      = longint'($signed(a));
        sb      = longint'($signed(b));
        res     = '0;
        m_carry = 1'b0;
        m_ovf   = 1'b0;
        case (op)
            alu_pkg::OP_ADD: begin
                res     = a + b;
                sr      = sa + sb;
                m_carry = (longint'(a) + longint'(b)) > longint'({W{1'b1}});
                m_ovf   = (sr > SMAX) || (sr < SMIN);
            end
            alu_pkg::OP_SUB: begin
                res     = a - b;
                sr      = sa - sb;
                m_carry = a < b;
                m_ovf   = (sr > SMAX) || (sr < SMIN);
            end
            alu_pkg::OP_AND:  res = a & b;
            alu_pkg::OP_OR:   res = a | b;
            alu_pkg::OP_NOT:  res = ~a;
            alu_pkg::OP_XOR:  res = a ^ b;
            alu_pkg::OP_RAND: res = W'(a == {W{1'b1}});
            alu_pkg::OP_ROR:  res = W'(a != '0);
            alu_pkg::OP_RXOR: res = W'(^a);
            alu_pkg::OP_LSL, alu_pkg::OP_ASL: begin
                res     = a << 1;
                m_carry = a[W-1];
            end
            alu_pkg::OP_LSR:  res = a >> 1;
            alu_pkg::OP_ASR:  res = W'($signed(a) >>> 1);
            alu_pkg::OP_CSL:  res = (a << 1) | (a >> (W - 1));
            alu_pkg::OP_CSR:  res = (a >> 1) | (a << (W - 1));
            alu_pkg::OP_INC:  res = a + W'(1);
            alu_pkg::OP_DEC:  res = a - W'(1);
            default:          res = '0;
        endcase
        m_r    = res;
        m_zero = (res == '0);
    endfunction

    function automatic logic [alu_pkg::FLAG_W-1:0] model_flags();
        logic [alu_pkg::FLAG_W-1:0] f;
        f                           = '0;
        f[alu_pkg::FLAG_OVF]   = m_ovf;
        f[alu_pkg::FLAG_ZERO]  = m_zero;
        f[alu_pkg::FLAG_CARRY] = m_carry;
        f[alu_pkg::FLAG_STACK] = m_stk;
        return f;
    endfunction

    function automatic logic [7:0] pick_opcode(input int idx);
        if (idx < 18) begin
            return 8'(idx);
        end else if (idx < 23) begin
            return 8'(8'hFB + idx - 18);
        end else if (idx == 23) begin
            return 8'h12;
        end else if (idx == 24) begin
            return 8'h80;
        end
        return 8'hFA;
    endfunction

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        check_value("data_valid_o", W'(data_valid_o), W'(exp_dv));
        if (exp_dv) begin
            check_value("data_o", data_o, exp_data);
        end
        check_value("addr_valid_o", W'(addr_valid_o), W'(exp_av));
        if (exp_av) begin
            check_value("addr_o", addr_o, exp_addr);
        end
        check_value("flags_o", W'(flags_o), W'(model_flags()));
    endtask

    // drive one command at the falling edge, check its outputs one cycle later
    task automatic run_cmd(input logic [7:0] op, input logic [3:0] sa, input logic [3:0] sb,
                           input logic [W-1:0] d);
        logic [W-1:0] a_val;
        logic [W-1:0] b_val;
        op_valid_i = 1'b1;
        opcode_i   = op;
        sel_a_i    = sa;
        sel_b_i    = sb;
        data_i_i   = d;
        a_val      = model_read(sa, d);
        b_val      = model_read(sb, d);
        exp_dv     = 1'b0;
        exp_av     = 1'b0;
        if (op >= alu_pkg::OP_ADD && op <= alu_pkg::OP_DEC) begin
            model_alu(op, a_val, b_val);
        end else if (op == alu_pkg::OP_PUSH) begin
            exp_dv   = 1'b1;
            exp_data = a_val;
            exp_av   = 1'b1;
            exp_addr = m_ss + m_sp;
            if (m_sp == {W{1'b1}}) begin
                m_stk = 1'b1;
            end else begin
                m_sp  = m_sp + W'(1);
                m_stk = 1'b0;
            end
        end else if (op == alu_pkg::OP_POP) begin
            exp_av   = 1'b1;
            exp_addr = m_ss + m_sp - W'(1);
            if (m_sp == '0) begin
                m_stk = 1'b1;
            end else begin
                m_sp  = m_sp - W'(1);
                m_stk = 1'b0;
            end
            model_write(sa, d);
        end else if (op == alu_pkg::OP_MOV_RA) begin
            exp_dv   = 1'b1;
            exp_data = a_val;
        end else if (op == alu_pkg::OP_MOV_AR) begin
            model_write(sb, d);
        end else if (op == alu_pkg::OP_MOV_RR) begin
            model_write(sb, a_val);
        end
        @(negedge clk);
        check_outputs();
        op_valid_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset();
        check_value("data_valid_o", W'(data_valid_o), '0);
        check_value("addr_valid_o", W'(addr_valid_o), '0);
        check_value("flags_o", W'(flags_o), '0);
        for (int s = 1; s <= 7; s++) begin
            run_cmd(alu_pkg::OP_MOV_RA, 4'(s), alu_pkg::SEL_NONE, '0);
        end
        end_test("reset");
    endtask

    task automatic test_moves();
        for (int s = 1; s <= 6; s++) begin
            run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, 4'(s), rand_word());
        end
        for (int i = 0; i < 10; i++) begin
            run_cmd(alu_pkg::OP_MOV_RR, 4'(1 + rand_below(6)), 4'(1 + rand_below(6)),
                    rand_word());
        end
        for (int s = 1; s <= 6; s++) begin
            run_cmd(alu_pkg::OP_MOV_RA, 4'(s), alu_pkg::SEL_NONE, rand_word());
        end
        end_test("moves");
    endtask

    task automatic test_alu();
        for (int i = 0; i < ALU_LEN; i++) begin
            if (i % 8 == 0) begin
                run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, 4'(1 + rand_below(6)),
                        rand_word());
            end
            run_cmd(8'(1 + rand_below(17)), 4'(1 + rand_below(8)), 4'(1 + rand_below(8)),
                    rand_word());
            // read R back through the data port
            run_cmd(alu_pkg::OP_MOV_RA, alu_pkg::SEL_R_SS, alu_pkg::SEL_NONE, rand_word());
        end
        end_test("alu operations");
    endtask

    task automatic test_stack();
        logic [3:0] sel;
        run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, alu_pkg::SEL_R_SS, rand_word());
        run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, alu_pkg::SEL_IMM_SP, W'(4));
        for (int i = 0; i < STACK_LEN; i++) begin
            run_cmd(alu_pkg::OP_PUSH, 4'(1 + rand_below(6)), alu_pkg::SEL_NONE, rand_word());
            sel = 4'(1 + rand_below(6));
            run_cmd(alu_pkg::OP_POP, sel, alu_pkg::SEL_NONE, rand_word());
            run_cmd(alu_pkg::OP_MOV_RA, sel, alu_pkg::SEL_NONE, rand_word());
        end
        end_test("stack");
    endtask

    task automatic test_stack_limits();
        run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, alu_pkg::SEL_R_SS, rand_word());
        run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, alu_pkg::SEL_IMM_SP, {W{1'b1}});
        // the second access must hit the same address
        for (int i = 0; i < 2; i++) begin
            run_cmd(alu_pkg::OP_PUSH, 4'(1 + rand_below(6)), alu_pkg::SEL_NONE, rand_word());
            if (flags_o[alu_pkg::FLAG_STACK] !== 1'b1) begin
                $display("stack flag did not set on a push with SP at its maximum");
                test_errors++;
            end
        end
        run_cmd(alu_pkg::OP_MOV_AR, alu_pkg::SEL_NONE, alu_pkg::SEL_IMM_SP, '0);
        for (int i = 0; i < 2; i++) begin
            run_cmd(alu_pkg::OP_POP, 4'(1 + rand_below(6)), alu_pkg::SEL_NONE, rand_word());
            if (flags_o[alu_pkg::FLAG_STACK] !== 1'b1) begin
                $display("stack flag did not set on a pop with SP at zero");
                test_errors++;
            end
        end
        run_cmd(alu_pkg::OP_PUSH, 4'(1 + rand_below(6)), alu_pkg::SEL_NONE, rand_word());
        end_test("stack limits");
    endtask

    task automatic test_mix();
        for (int i = 0; i < MIX_LEN; i++) begin
            run_cmd(pick_opcode(rand_below(26)), 4'(rand_below(9)), 4'(rand_below(9)),
                    rand_word());
        end
        end_test("random mix");
    endtask

    initial begin
        rst_n      = 1'b0;
        op_valid_i = 1'b0;
        opcode_i   = '0;
        sel_a_i    = '0;
        sel_b_i    = '0;
        data_i_i   = '0;
        for (int s = 1; s <= 6; s++) begin
            m_gpr[s] = '0;
        end
        m_r     = '0;
        m_ss    = '0;
        m_sp    = '0;
        m_ovf   = 1'b0;
        m_zero  = 1'b0;
        m_carry = 1'b0;
        m_stk   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_moves();
        test_alu();
        test_stack();
        test_stack_limits();
        test_mix();
        assert_failures = u_dut.u_checker.fail_count;
        total_errors += assert_failures;
        $display("tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, total_errors, assert_failures);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/alu_pkg.sv
verilog/alu_core.sv
verilog/stack_unit.sv
verilog/register_bank.sv
verilog/alu_top.sv
verification/alu_checker.sv
verification/alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the alu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module alu_tb --Mdir obj_dir -o alu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# assertion errors must not stop the run before the final report
./obj_dir/alu_tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
